// File: all.f
vm_types_pkg.sv
vm_price_pkg.sv
vm_price_regs.sv
calculate_current_state.sv
vm_state_regs.sv
change_return.sv
vending_machine.sv
vending_machine_props.sv
tb_vending_machine.sv

// File: tb_vending_machine.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vending_machine;

	import vm_types_pkg::*;
	import vm_price_pkg::*;

	localparam int WAIT_CYCLES = 10;
	// the tests take well under 100 cycles
	localparam int MAX_CYCLES = 400;

	logic       clk;
	logic       i_rst_n;
	coin_vec_t  i_input_coin;
	item_vec_t  i_select_item;
	logic       i_trigger_return;
	logic       i_cfg_wr;
	cfg_word_t  i_cfg_data;
	vm_status_t o_status;

	int price_model [NUM_ITEMS];
	int coin_model [NUM_COINS];
	int exp_balance;
	int error_count;
	int tests_ok;
	int tests_bad;
	int cycle_count;

	vending_machine vending_machine_i (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_input_coin     (i_input_coin),
		.i_select_item    (i_select_item),
		.i_trigger_return (i_trigger_return),
		.i_cfg_wr         (i_cfg_wr),
		.i_cfg_data       (i_cfg_data),
		.o_status         (o_status)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: no result after %0d clock cycles", MAX_CYCLES);
		$display("test failed");
		$finish;
	end

	function automatic int coin_sum(input coin_vec_t coins);
		int total;
		total = 0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (coins[i]) begin
				total += coin_model[i];
			end
		end
		return total;
	endfunction

	// largest coin not above the balance, zero if none fits
	function automatic coin_vec_t greedy_pick(input int balance);
		coin_vec_t pick;
		int best;
		pick = '0;
		best = 0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (coin_model[i] > best && coin_model[i] <= balance) begin
				best = coin_model[i];
				pick = coin_vec_t'(1 << i);
			end
		end
		return pick;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task automatic check_status(input int bal, input item_vec_t disp, input coin_vec_t ret);
		item_vec_t avail;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			avail[i] = (bal >= price_model[i]);
		end
		check_value("o_status.balance", o_status.balance, bal);
		check_value("o_status.available", o_status.available, avail);
		check_value("o_status.dispensed", o_status.dispensed, disp);
		check_value("o_status.returned", o_status.returned, ret);
	endtask

	// inputs change at the rising edge, outputs are read at the falling edge
	task automatic drive_cycle(input coin_vec_t coins, input item_vec_t sel, input logic ret);
		@(posedge clk);
		i_input_coin     <= coins;
		i_select_item    <= sel;
		i_trigger_return <= ret;
		@(negedge clk);
	endtask

	task automatic write_cfg(input logic cfg_sel, input logic [1:0] cfg_index,
		input int cfg_value);
		@(posedge clk);
		i_input_coin     <= '0;
		i_select_item    <= '0;
		i_trigger_return <= 1'b0;
		i_cfg_wr         <= 1'b1;
		i_cfg_data       <= '{sel: cfg_sel, index: cfg_index,
			value: cfg_value[TOTAL_BITS-1:0]};
		@(posedge clk);
		i_cfg_wr <= 1'b0;
		@(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d mismatches", name, error_count - errs_before);
		end
	endtask

	task automatic test_reset();
		int errs;
		errs = error_count;
		@(negedge clk);
		check_status(0, '0, '0);
		report_test("reset state", errs);
	endtask

	task automatic test_coins();
		int errs;
		coin_vec_t coins;
		errs = error_count;
		for (int n = 0; n < 6; n++) begin
			// any non-empty mix of the three coins
			coins = coin_vec_t'($urandom % 7 + 1);
			drive_cycle(coins, '0, 1'b0);
			check_status(exp_balance, '0, '0);
			exp_balance += coin_sum(coins);
		end
		drive_cycle('0, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		report_test("coin credit", errs);
	endtask

	task automatic test_select();
		int errs;
		errs = error_count;
		// six coin mixes are worth at least 600, enough for item 0
		drive_cycle('0, 4'b0001, 1'b0);
		check_status(exp_balance, 4'b0001, '0);
		exp_balance -= price_model[0];
		while (exp_balance >= price_model[3]) begin
			drive_cycle('0, 4'b1000, 1'b0);
			check_status(exp_balance, 4'b1000, '0);
			exp_balance -= price_model[3];
		end
		// too little left for item 3
		drive_cycle('0, 4'b1000, 1'b0);
		check_status(exp_balance, '0, '0);
		drive_cycle('0, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		report_test("item selection", errs);
	endtask

	task automatic test_config();
		int errs;
		errs = error_count;
		// item 3 now costs exactly the balance
		price_model[3] = exp_balance;
		write_cfg(~CFG_SEL_COIN, 2'd3, exp_balance);
		check_status(exp_balance, '0, '0);
		coin_model[0] = 300;
		write_cfg(CFG_SEL_COIN, 2'd0, 300);
		drive_cycle(3'b001, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		exp_balance += coin_sum(3'b001);
		drive_cycle('0, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		report_test("price and coin config", errs);
	endtask

	task automatic test_forced_return();
		int errs;
		int start;
		int paid;
		coin_vec_t pick;
		errs = error_count;
		paid = 0;
		drive_cycle(3'b111, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		exp_balance += coin_sum(3'b111);
		drive_cycle('0, '0, 1'b1);
		check_status(exp_balance, '0, '0);
		start = exp_balance;
		// one coin per cycle until nothing fits
		do begin
			drive_cycle('0, '0, 1'b0);
			pick = greedy_pick(exp_balance);
			check_status(exp_balance, '0, pick);
			paid += coin_sum(o_status.returned);
			exp_balance -= coin_sum(pick);
		end while (o_status.returned != '0);
		check_value("returned total", paid, start - exp_balance);
		check_value("coin fitting the remainder", greedy_pick(o_status.balance), 0);
		report_test("forced return", errs);
	endtask

	task automatic test_idle_return();
		int errs;
		coin_vec_t pick;
		errs = error_count;
		// remainder is below every coin, so nothing is paid here
		drive_cycle(3'b111, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		exp_balance += coin_sum(3'b111);
		// first idle cycle sees the reloaded timer
		for (int n = 0; n < WAIT_CYCLES; n++) begin
			drive_cycle('0, '0, 1'b0);
			check_status(exp_balance, '0, '0);
		end
		drive_cycle('0, '0, 1'b0);
		pick = greedy_pick(exp_balance);
		check_status(exp_balance, '0, pick);
		exp_balance -= coin_sum(pick);
		// still paying in the coin cycle, stopped after the next edge
		drive_cycle(3'b010, '0, 1'b0);
		pick = greedy_pick(exp_balance);
		check_status(exp_balance, '0, pick);
		exp_balance += coin_sum(3'b010) - coin_sum(pick);
		drive_cycle('0, '0, 1'b0);
		check_status(exp_balance, '0, '0);
		report_test("inactivity return", errs);
	endtask

	initial begin
		void'($urandom(70));
		price_model      = '{400, 500, 1000, 2000};
		coin_model       = '{100, 500, 1000};
		exp_balance      = 0;
		error_count      = 0;
		tests_ok         = 0;
		tests_bad        = 0;
		i_rst_n          = 1'b0;
		i_input_coin     = '0;
		i_select_item    = '0;
		i_trigger_return = 1'b0;
		i_cfg_wr         = 1'b0;
		i_cfg_data       = '0;
		repeat (3) @(posedge clk);
		i_rst_n <= 1'b1;
		test_reset();
		test_coins();
		test_select();
		test_config();
		test_forced_return();
		test_idle_return();
		$display("summary: %0d ok, %0d with mismatches", tests_ok, tests_bad);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vending_machine_props.sv
`timescale 1ns/10ps
`default_nettype none

module vending_machine_props (
	input wire                           clk,
	input wire                           i_rst_n,
	input wire vm_types_pkg::coin_vec_t  i_input_coin,
	input wire vm_types_pkg::item_vec_t  i_select_item,
	input wire vm_types_pkg::coin_vec_t  i_return_coin,
	input wire vm_types_pkg::item_vec_t  i_output_item,
	input wire vm_types_pkg::money_t     i_current_total
);

	// the dispenser pays one coin per cycle at most
	return_one_hot: assert property (@(posedge clk) disable iff (!i_rst_n)
		$onehot0(i_return_coin))
		else $error("more than one coin returned in a cycle");

	// nothing comes out that was not asked for
	dispense_subset: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_output_item & ~i_select_item) == '0)
		else $error("item dispensed without a selection");

	balance_drains: assert property (@(posedge clk) disable iff (!i_rst_n)
		(|i_return_coin && !(|i_input_coin)) |=> i_current_total <= $past(i_current_total))
		else $error("balance grew during a coin return");

endmodule

bind vending_machine vending_machine_props vending_machine_props_i (
	.clk             (clk),
	.i_rst_n         (i_rst_n),
	.i_input_coin    (i_input_coin),
	.i_select_item   (i_select_item),
	.i_return_coin   (return_coin),
	.i_output_item   (output_item),
	.i_current_total (current_total)
);

`default_nettype wire

// File: vending_machine.sv
`timescale 1ns/10ps
`default_nettype none

module vending_machine #(
	parameter int WAIT_CYCLES = 10
) (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire vm_types_pkg::coin_vec_t  i_input_coin,
	input  wire vm_types_pkg::item_vec_t  i_select_item,
	input  wire                           i_trigger_return,
	input  wire                           i_cfg_wr,
	input  wire vm_price_pkg::cfg_word_t  i_cfg_data,
	output vm_types_pkg::vm_status_t      o_status
);

	import vm_types_pkg::*;

	price_tbl_t         prices;
	coin_tbl_t          coin_values;
	money_t             current_total;
	money_t             current_total_nxt;
	logic signed [31:0] wait_time;
	logic               time_to_return;
	item_vec_t          available_item;
	item_vec_t          output_item;
	coin_vec_t          return_coin;

	vm_price_regs vm_price_regs_i (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_cfg_wr      (i_cfg_wr),
		.i_cfg_data    (i_cfg_data),
		.o_prices      (prices),
		.o_coin_values (coin_values)
	);

	calculate_current_state calculate_current_state_i (
		.i_input_coin        (i_input_coin),
		.i_select_item       (i_select_item),
		.i_return_coin       (return_coin),
		.i_prices            (prices),
		.i_coin_values       (coin_values),
		.i_current_total     (current_total),
		.i_wait_time         (wait_time),
		.o_current_total_nxt (current_total_nxt),
		.o_available_item    (available_item),
		.o_output_item       (output_item),
		.o_time_to_return    (time_to_return)
	);

	vm_state_regs #(
		.WAIT_CYCLES (WAIT_CYCLES)
	) vm_state_regs_i (
		.clk                 (clk),
		.i_rst_n             (i_rst_n),
		.i_current_total_nxt (current_total_nxt),
		.i_input_coin        (i_input_coin),
		.i_select_item       (i_select_item),
		.i_trigger_return    (i_trigger_return),
		.o_current_total     (current_total),
		.o_wait_time         (wait_time)
	);

	change_return change_return_i (
		.i_time_to_return (time_to_return),
		.i_current_total  (current_total),
		.i_coin_values    (coin_values),
		.o_return_coin    (return_coin)
	);

	// dispensed and returned bits are live in the current cycle
	assign o_status = '{
		balance:   current_total,
		available: available_item,
		dispensed: output_item,
		returned:  return_coin
	};

endmodule

`default_nettype wire

// File: change_return.sv
`timescale 1ns/10ps
`default_nettype none

module change_return (
	input  wire                           i_time_to_return,
	input  wire vm_types_pkg::money_t     i_current_total,
	input  wire vm_types_pkg::coin_tbl_t  i_coin_values,
	output vm_types_pkg::coin_vec_t       o_return_coin
);

	import vm_types_pkg::*;

	money_t    best_value;
	coin_vec_t pick;

	// largest coin that still fits in the balance
	always_comb begin
		best_value = '0;
		pick       = '0;
		for (int i = 0; i < NUM_COINS; i++) begin
			// a zero-valued coin would never drain the balance
			if (i_coin_values[i] != '0
				&& i_coin_values[i] <= i_current_total
				&& i_coin_values[i] > best_value) begin
				best_value = i_coin_values[i];
				pick       = '0;
				pick[i]    = 1'b1;
			end
		end
	end

	// one coin per cycle, only while a return is due
	assign o_return_coin = i_time_to_return ? pick : '0;

endmodule

`default_nettype wire

// File: vm_state_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vm_state_regs #(
	parameter int WAIT_CYCLES = 10
) (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire vm_types_pkg::money_t     i_current_total_nxt,
	input  wire vm_types_pkg::coin_vec_t  i_input_coin,
	input  wire vm_types_pkg::item_vec_t  i_select_item,
	input  wire                           i_trigger_return,
	output vm_types_pkg::money_t          o_current_total,
	output logic signed [31:0]            o_wait_time
);

	logic activity;

	// any coin or selection counts, even one that buys nothing
	assign activity = (|i_input_coin) || (|i_select_item);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_current_total <= '0;
		end else begin
			o_current_total <= i_current_total_nxt;
		end
	end

	// inactivity countdown, stops at zero
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_wait_time <= WAIT_CYCLES;
		end else if (i_trigger_return) begin
			// explicit request wins over a coin in the same cycle
			o_wait_time <= '0;
		end else if (activity) begin
			o_wait_time <= WAIT_CYCLES;
		end else if (o_wait_time > 0) begin
			o_wait_time <= o_wait_time - 1;
		end
	end

endmodule

`default_nettype wire

// File: calculate_current_state.sv
`timescale 1ns/10ps
`default_nettype none

module calculate_current_state (
	input  wire vm_types_pkg::coin_vec_t   i_input_coin,
	input  wire vm_types_pkg::item_vec_t   i_select_item,
	input  wire vm_types_pkg::coin_vec_t   i_return_coin,
	input  wire vm_types_pkg::price_tbl_t  i_prices,
	input  wire vm_types_pkg::coin_tbl_t   i_coin_values,
	input  wire vm_types_pkg::money_t      i_current_total,
	input  wire signed [31:0]              i_wait_time,
	output vm_types_pkg::money_t           o_current_total_nxt,
	output vm_types_pkg::item_vec_t        o_available_item,
	output vm_types_pkg::item_vec_t        o_output_item,
	output logic                           o_time_to_return
);

	import vm_types_pkg::*;

	money_t input_total;
	money_t return_total;
	money_t output_total;

	// value of the coins dropped in this cycle
	always_comb begin
		input_total = '0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (i_input_coin[i]) begin
				input_total = input_total + i_coin_values[i];
			end
		end
	end

	// value of the coin paid out by the dispenser
	always_comb begin
		return_total = '0;
		for (int i = 0; i < NUM_COINS; i++) begin
			if (i_return_coin[i]) begin
				return_total = return_total + i_coin_values[i];
			end
		end
	end

	// items are paid from what is left after the returned coin,
	// and each granted item lowers the credit for the next one
	always_comb begin
		output_total  = '0;
		o_output_item = '0;
		for (int i = 0; i < NUM_ITEMS; i++) begin
			if (i_select_item[i]
				&& (i_current_total - return_total - output_total) >= i_prices[i]) begin
				o_output_item[i] = 1'b1;
				output_total     = output_total + i_prices[i];
			end
		end
	end

	assign o_current_total_nxt = i_current_total + input_total - output_total - return_total;

	// items the registered balance can pay for
	always_comb begin
		for (int i = 0; i < NUM_ITEMS; i++) begin
			o_available_item[i] = (i_current_total >= i_prices[i]);
		end
	end

	// timer ran out or was forced to zero
	assign o_time_to_return = (i_wait_time <= 0);

endmodule

`default_nettype wire

// File: vm_price_regs.sv
`timescale 1ns/10ps
`default_nettype none

module vm_price_regs (
	input  wire                           clk,
	input  wire                           i_rst_n,
	input  wire                           i_cfg_wr,
	input  wire vm_price_pkg::cfg_word_t  i_cfg_data,
	output vm_types_pkg::price_tbl_t      o_prices,
	output vm_types_pkg::coin_tbl_t       o_coin_values
);

	import vm_types_pkg::*;
	import vm_price_pkg::*;

	price_tbl_t prices_q;
	coin_tbl_t  coin_values_q;
	logic       wr_item;
	logic       wr_coin;

	// decode the write target from the select bit
	assign wr_item = i_cfg_wr && (i_cfg_data.sel != CFG_SEL_COIN);
	// there are only three coins, so index 3 is dropped
	assign wr_coin = i_cfg_wr && (i_cfg_data.sel == CFG_SEL_COIN)
		&& (int'(i_cfg_data.index) < NUM_COINS);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			prices_q <= DEFAULT_PRICES;
		end else if (wr_item) begin
			prices_q[i_cfg_data.index] <= i_cfg_data.value;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			coin_values_q <= DEFAULT_COIN_VALUES;
		end else if (wr_coin) begin
			coin_values_q[i_cfg_data.index] <= i_cfg_data.value;
		end
	end

	assign o_prices      = prices_q;
	assign o_coin_values = coin_values_q;

endmodule

`default_nettype wire

// File: vm_price_pkg.sv
`default_nettype none

package vm_price_pkg;

	// value of the select bit that addresses the coin table
	localparam logic CFG_SEL_COIN = 1'b1;

	// one run-time write: item price or coin value
	typedef struct packed {
		logic                 sel;
		logic [1:0]           index;
		vm_types_pkg::money_t value;
	} cfg_word_t;

	// item 0 is the cheapest
	localparam vm_types_pkg::price_tbl_t DEFAULT_PRICES = {
		16'd2000, 16'd1000, 16'd500, 16'd400
	};

	// coin 0 is the smallest
	localparam vm_types_pkg::coin_tbl_t DEFAULT_COIN_VALUES = {
		16'd1000, 16'd500, 16'd100
	};

endpackage

`default_nettype wire

// File: vm_types_pkg.sv
`default_nettype none

package vm_types_pkg;

	localparam int NUM_COINS  = 3;
	localparam int NUM_ITEMS  = 4;
	localparam int TOTAL_BITS = 16;

	// one bit per coin type, for insertion and return alike
	typedef logic [NUM_COINS-1:0]  coin_vec_t;
	// one bit per item
	typedef logic [NUM_ITEMS-1:0]  item_vec_t;
	typedef logic [TOTAL_BITS-1:0] money_t;

	// entry 0 sits in the low bits
	typedef money_t [NUM_ITEMS-1:0] price_tbl_t;
	typedef money_t [NUM_COINS-1:0] coin_tbl_t;

	// everything the outside world sees in one word
	typedef struct packed {
		money_t    balance;
		item_vec_t available;
		item_vec_t dispensed;
		coin_vec_t returned;
	} vm_status_t;

endpackage

`default_nettype wire
